// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/core_top.sv
`timescale 1ns/100ps

module core_top import rv_core_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC   = '0,
  parameter int              WITF_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  i_rst,
  input  logic                  i_inst_valid,
  input  logic [INST_W-1:0]     i_inst,
  output logic                  o_inst_ready,
  output logic                  o_valid,
  output logic [INST_W-1:0]     o_inst,
  output logic [XLEN-1:0]       o_pc,
  output logic                  o_wb_en,
  output logic [REG_ADDR_W-1:0] o_wb_rd,
  output logic [XLEN-1:0]       o_wb_data
);

  // stage links
  fetch_dec_if fd_link ();
  dec_exe_if   de_link ();
  exe_wb_if    ew_link ();
  witf_if      witf_link ();
  rf_read_if   rf_link ();

  // writeback side to regfile and witf
  logic                  rf_wen;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;
  logic                  witf_pop;

  fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
    .clk(clk), .i_rst(i_rst), .i_inst_valid(i_inst_valid), .i_inst(i_inst),
    .o_inst_ready(o_inst_ready), .dec(fd_link)
  );

  decode_stage u_decode (
    .clk(clk), .i_rst(i_rst), .fet(fd_link), .exe(de_link), .wt(witf_link), .rf(rf_link)
  );

  witf #(.WITF_DEPTH(WITF_DEPTH)) u_witf (
    .clk(clk), .i_rst(i_rst), .dec(witf_link), .i_pop(witf_pop)
  );

  regfile u_regfile (
    .clk(clk), .i_rst(i_rst), .rd(rf_link),
    .i_wen(rf_wen), .i_waddr(rf_waddr), .i_wdata(rf_wdata)
  );

  execute_stage u_execute (.clk(clk), .i_rst(i_rst), .dec(de_link), .wb(ew_link));

  writeback_stage u_writeback (
    .ex(ew_link), .o_rf_wen(rf_wen), .o_rf_waddr(rf_waddr), .o_rf_wdata(rf_wdata),
    .o_witf_pop(witf_pop), .o_valid(o_valid), .o_inst(o_inst), .o_pc(o_pc),
    .o_wb_en(o_wb_en), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data)
  );

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/100ps

module decode_stage import rv_core_pkg::*; (
  input  logic          clk,
  input  logic          i_rst,
  fetch_dec_if.consumer fet,
  dec_exe_if.producer   exe,
  witf_if.producer      wt,
  rf_read_if.producer   rf
);

  logic [INST_W-1:0]     inst;
  opcode_e               opcode;
  logic [2:0]            funct3;
  logic                  alt;
  logic [REG_ADDR_W-1:0] rd;
  logic [REG_ADDR_W-1:0] rs1_idx;
  logic [REG_ADDR_W-1:0] rs2_idx;
  logic [XLEN-1:0]       imm_i;
  logic [XLEN-1:0]       imm_u;
  logic [XLEN-1:0]       op_b;
  alu_op_e               alu_op;
  logic                  reg_wr;
  logic                  use_rs1;
  logic                  use_rs2;
  logic                  stall;
  logic                  out_free;
  logic                  handoff;

  // instruction fields
  assign inst = fet.pkt.inst;
  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign alt = inst[30];
  assign rd = inst[11:7];
  assign imm_i = {{(XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_u = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};

  // which sources are real, which instructions write back
  always_comb begin
    reg_wr = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (opcode)
      OPC_OP: begin
        reg_wr = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      OPC_OP_IMM: begin
        reg_wr = 1'b1;
        use_rs1 = 1'b1;
      end
      OPC_LUI: begin
        reg_wr = 1'b1;
      end
      default: begin
        reg_wr = 1'b0;
      end
    endcase
  end

  // funct3 to alu op; bit 30 picks sub only for register form, sra for both
  always_comb begin
    case (funct3)
      3'b000:  alu_op = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
      3'b001:  alu_op = ALU_SLL;
      3'b010:  alu_op = ALU_SLT;
      3'b011:  alu_op = ALU_SLTU;
      3'b100:  alu_op = ALU_XOR;
      3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  alu_op = ALU_OR;
      default: alu_op = ALU_AND;
    endcase
    if (opcode == OPC_LUI) begin
      alu_op = ALU_PASS_B;
    end
  end

  // unused sources read as x0, which never hits in the witf
  assign rs1_idx = use_rs1 ? inst[19:15] : '0;
  assign rs2_idx = use_rs2 ? inst[24:20] : '0;
  assign rf.rs1 = rs1_idx;
  assign rf.rs2 = rs2_idx;
  assign wt.rs1 = rs1_idx;
  assign wt.rs2 = rs2_idx;
  assign wt.rd = rd;

  // second operand
  assign op_b = use_rs2 ? rf.rdata2 : ((opcode == OPC_LUI) ? imm_u : imm_i);

  // handshake, ready_go folded into allow_in
  assign stall = fet.valid && (wt.raw || wt.full);
  assign out_free = !exe.valid || exe.allow_in;
  assign fet.allow_in = out_free && !stall;
  assign handoff = fet.valid && fet.allow_in;

  // book the destination as in flight
  assign wt.push = handoff && reg_wr && (rd != '0);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      exe.valid <= 1'b0;
    end else if (out_free) begin
      // stalled item leaves a bubble behind
      exe.valid <= handoff;
    end
  end

  always_ff @(posedge clk) begin
    if (handoff) begin
      exe.uop.pc <= fet.pkt.pc;
      exe.uop.inst <= inst;
      exe.uop.alu_op <= alu_op;
      exe.uop.op_a <= rf.rdata1;
      exe.uop.op_b <= op_b;
      exe.uop.rd <= rd;
      exe.uop.reg_wr <= reg_wr;
    end
  end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/100ps

module execute_stage import rv_core_pkg::*; (
  input  logic         clk,
  input  logic         i_rst,
  dec_exe_if.consumer  dec,
  exe_wb_if.producer   wb
);

  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic [5:0]      shamt;
  logic [XLEN-1:0] result;

  assign a = dec.uop.op_a;
  assign b = dec.uop.op_b;
  // rv64 shifts use six bits
  assign shamt = b[5:0];

  always_comb begin
    case (dec.uop.alu_op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = XLEN'($signed(a) < $signed(b));
      ALU_SLTU:   result = XLEN'(a < b);
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $signed(a) >>> shamt;
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  // single cycle, so only downstream space matters
  assign dec.allow_in = !wb.valid || wb.allow_in;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wb.valid <= 1'b0;
    end else if (dec.allow_in) begin
      wb.valid <= dec.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec.valid && dec.allow_in) begin
      wb.ret.pc <= dec.uop.pc;
      wb.ret.inst <= dec.uop.inst;
      wb.ret.rd <= dec.uop.rd;
      wb.ret.reg_wr <= dec.uop.reg_wr;
      wb.ret.result <= result;
    end
  end

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage import rv_core_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic              clk,
  input  logic              i_rst,
  input  logic              i_inst_valid,
  input  logic [INST_W-1:0] i_inst,
  output logic              o_inst_ready,
  fetch_dec_if.producer     dec
);

  logic [XLEN-1:0] pc_q;
  logic            accept;

  // allow_in: register empty, or decode takes the held item this edge
  assign o_inst_ready = !dec.valid || dec.allow_in;
  assign accept = i_inst_valid && o_inst_ready;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      dec.valid <= 1'b0;
      pc_q <= RESET_PC;
    end else begin
      // refill or drain the fetch/decode register
      if (o_inst_ready) begin
        dec.valid <= i_inst_valid;
      end
      // sequential pc, no branches
      if (accept) begin
        pc_q <= pc_q + XLEN'(4);
      end
    end
  end

  // payload only
  always_ff @(posedge clk) begin
    if (accept) begin
      dec.pkt.pc <= pc_q;
      dec.pkt.inst <= i_inst;
    end
  end

endmodule

// File: logic/pipe_links.sv
`timescale 1ns/100ps

// fetch register to decode
interface fetch_dec_if import rv_core_pkg::*; ();
  logic       valid;
  fetch_pkt_t pkt;
  logic       allow_in;

  modport producer (output valid, output pkt, input allow_in);
  modport consumer (input valid, input pkt, output allow_in);
endinterface

// decode register to execute
interface dec_exe_if import rv_core_pkg::*; ();
  logic valid;
  uop_t uop;
  logic allow_in;

  modport producer (output valid, output uop, input allow_in);
  modport consumer (input valid, input uop, output allow_in);
endinterface

// execute register to writeback
interface exe_wb_if import rv_core_pkg::*; ();
  logic    valid;
  retire_t ret;
  logic    allow_in;

  modport producer (output valid, output ret, input allow_in);
  modport consumer (input valid, input ret, output allow_in);
endinterface

// decode dispatch and hazard lookup against the witf
interface witf_if import rv_core_pkg::*; ();
  logic                  push;
  logic [REG_ADDR_W-1:0] rd;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic                  raw;
  logic                  full;

  modport producer (output push, output rd, output rs1, output rs2, input raw, input full);
  modport consumer (input push, input rd, input rs1, input rs2, output raw, output full);
endinterface

// operand read ports, combinational
interface rf_read_if import rv_core_pkg::*; ();
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [XLEN-1:0]       rdata1;
  logic [XLEN-1:0]       rdata2;

  modport producer (output rs1, output rs2, input rdata1, input rdata2);
  modport consumer (input rs1, input rs2, output rdata1, output rdata2);
endinterface

// File: logic/regfile.sv
`timescale 1ns/100ps

module regfile import rv_core_pkg::*; (
  input  logic                  clk,
  input  logic                  i_rst,
  rf_read_if.consumer           rd,
  input  logic                  i_wen,
  input  logic [REG_ADDR_W-1:0] i_waddr,
  input  logic [XLEN-1:0]       i_wdata
);

  logic [XLEN-1:0] regs [NUM_REGS];

  // async reads, x0 hardwired
  assign rd.rdata1 = (rd.rs1 == '0) ? '0 : regs[rd.rs1];
  assign rd.rdata2 = (rd.rs2 == '0) ? '0 : regs[rd.rs2];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin
      // x0 writes dropped
      regs[i_waddr] <= i_wdata;
    end
  end

endmodule

// File: logic/rv_core_pkg.sv
package rv_core_pkg;

  // datapath widths
  localparam int XLEN       = 64;
  localparam int INST_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // major opcodes the core executes, anything else retires as a no-op
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  // alu functions
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // fetch to decode payload
  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [INST_W-1:0] inst;
  } fetch_pkt_t;

  // decoded instruction, operands already read
  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [INST_W-1:0]     inst;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_wr;
  } uop_t;

  // finished instruction on its way to writeback
  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [INST_W-1:0]     inst;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_wr;
    logic [XLEN-1:0]       result;
  } retire_t;

endpackage

// File: logic/witf.sv
`timescale 1ns/100ps

module witf import rv_core_pkg::*; #(
  parameter int WITF_DEPTH = 4
) (
  input  logic       clk,
  input  logic       i_rst,
  witf_if.consumer   dec,
  input  logic       i_pop
);

  localparam int PTR_W = (WITF_DEPTH > 1) ? $clog2(WITF_DEPTH) : 1;

  logic [REG_ADDR_W-1:0] ent [WITF_DEPTH];
  logic [WITF_DEPTH-1:0] vld;
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;

  // any in-flight writer of a source register
  always_comb begin
    dec.raw = 1'b0;
    for (int i = 0; i < WITF_DEPTH; i++) begin
      if (vld[i] && ((ent[i] == dec.rs1) || (ent[i] == dec.rs2))) begin
        dec.raw = 1'b1;
      end
    end
  end

  assign dec.full = &vld;

  // pointers wrap at depth, depth need not be a power of two
  always_ff @(posedge clk) begin
    if (i_rst) begin
      vld <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      // pop first so a same-slot push wins
      if (i_pop) begin
        vld[rd_ptr] <= 1'b0;
        rd_ptr <= (rd_ptr == PTR_W'(WITF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (dec.push) begin
        vld[wr_ptr] <= 1'b1;
        wr_ptr <= (wr_ptr == PTR_W'(WITF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
    end
  end

  // entry storage
  always_ff @(posedge clk) begin
    if (dec.push) begin
      ent[wr_ptr] <= dec.rd;
    end
  end

endmodule

// File: logic/writeback_stage.sv
`timescale 1ns/100ps

module writeback_stage import rv_core_pkg::*; (
  exe_wb_if.consumer            ex,
  output logic                  o_rf_wen,
  output logic [REG_ADDR_W-1:0] o_rf_waddr,
  output logic [XLEN-1:0]       o_rf_wdata,
  output logic                  o_witf_pop,
  output logic                  o_valid,
  output logic [INST_W-1:0]     o_inst,
  output logic [XLEN-1:0]       o_pc,
  output logic                  o_wb_en,
  output logic [REG_ADDR_W-1:0] o_wb_rd,
  output logic [XLEN-1:0]       o_wb_data
);

  // retire side never back-pressures
  assign ex.allow_in = 1'b1;

  // register write, lands at the edge closing this cycle
  assign o_rf_wen = ex.valid && ex.ret.reg_wr;
  assign o_rf_waddr = ex.ret.rd;
  assign o_rf_wdata = ex.ret.result;

  // x0 was never pushed into the witf
  assign o_witf_pop = o_rf_wen && (ex.ret.rd != '0);

  // retire trace
  assign o_valid = ex.valid;
  assign o_inst = ex.ret.inst;
  assign o_pc = ex.ret.pc;
  assign o_wb_en = o_rf_wen;
  assign o_wb_rd = ex.ret.rd;
  assign o_wb_data = ex.ret.result;

endmodule

// File: verification/core_model.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// lcg step over a 32-bit state
function automatic logic [31:0] lcg_next(inout logic [31:0] state);
  state = state * 32'd1664525 + 32'd1013904223;
  return state;
endfunction

// register form
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

// immediate form
function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd);
  return {imm, rs1, f3, rd, OPC_OP_IMM};
endfunction

// immediate shifts with a six bit shamt and bit 30 for arithmetic
function automatic logic [31:0] enc_shift(input logic [2:0] f3, input logic sra,
                                          input logic [4:0] rs1, input logic [5:0] shamt,
                                          input logic [4:0] rd);
  return enc_i({1'b0, sra, 4'b0000, shamt}, rs1, f3, rd);
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, OPC_LUI};
endfunction

// expected architectural effect of one instruction
function automatic void ref_exec(input logic [31:0] inst,
                                 input logic [XLEN-1:0] regs [NUM_REGS],
                                 output logic exp_wr, output logic [4:0] exp_rd,
                                 output logic [XLEN-1:0] exp_res);
  logic [6:0]      opc;
  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic [5:0]      sh;
  logic            is_reg;
  opc = inst[6:0];
  is_reg = (opc == OPC_OP);
  a = regs[inst[19:15]];
  b = is_reg ? regs[inst[24:20]] : {{52{inst[31]}}, inst[31:20]};
  sh = b[5:0];
  exp_rd = inst[11:7];
  exp_wr = 1'b1;
  exp_res = '0;
  if (opc == OPC_LUI) begin
    exp_res = {{32{inst[31]}}, inst[31:12], 12'h000};
  end else if (is_reg || opc == OPC_OP_IMM) begin
    case (inst[14:12])
      3'd0: exp_res = (is_reg && inst[30]) ? a - b : a + b;
      3'd1: exp_res = a << sh;
      3'd2: exp_res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      3'd3: exp_res = (a < b) ? 64'd1 : 64'd0;
      3'd4: exp_res = a ^ b;
      3'd5: begin
        // arithmetic shift keeps the sign bit
        if (inst[30]) begin
          exp_res = $signed(a) >>> sh;
        end else begin
          exp_res = a >> sh;
        end
      end
      3'd6: exp_res = a | b;
      default: exp_res = a & b;
    endcase
  end else begin
    // anything else is a no-op
    exp_wr = 1'b0;
  end
endfunction

`endif

// File: verification/tb_core_top.sv
`timescale 1ns/100ps

module tb_core_top import rv_core_pkg::*; ();

  localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;
  // small witf so back-to-back writers fill it
  localparam int WITF_DEPTH = 2;
  localparam int NUM_RANDOM = 500;

  logic                  clk;
  logic                  i_rst;
  logic                  i_inst_valid;
  logic [INST_W-1:0]     i_inst;
  logic                  o_inst_ready;
  logic                  o_valid;
  logic [INST_W-1:0]     o_inst;
  logic [XLEN-1:0]       o_pc;
  logic                  o_wb_en;
  logic [REG_ADDR_W-1:0] o_wb_rd;
  logic [XLEN-1:0]       o_wb_data;

  // program to send and what is accepted but not yet retired
  logic [INST_W-1:0] prog_q [$];
  string             name_q [$];
  logic [INST_W-1:0] exp_q [$];
  string             exp_name_q [$];
  logic [XLEN-1:0]   model_regs [NUM_REGS];
  int                errors;
  int                retired;
  bit                prog_ready;

  `include "core_model.svh"

  core_top #(.RESET_PC(RESET_PC), .WITF_DEPTH(WITF_DEPTH)) dut_i (
    .clk(clk), .i_rst(i_rst), .i_inst_valid(i_inst_valid), .i_inst(i_inst),
    .o_inst_ready(o_inst_ready), .o_valid(o_valid), .o_inst(o_inst), .o_pc(o_pc),
    .o_wb_en(o_wb_en), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                             input logic [XLEN-1:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic add_inst(input logic [INST_W-1:0] inst, input string name);
    prog_q.push_back(inst);
    name_q.push_back(name);
  endtask

  // mix of op, op-imm, lui and unknown opcodes on x0..x7
  function automatic logic [31:0] rand_inst(inout logic [31:0] state);
    logic [31:0] r;
    logic [31:0] k;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    r = lcg_next(state);
    k = lcg_next(state);
    rd = {2'b00, r[18:16]};
    rs1 = {2'b00, r[21:19]};
    rs2 = {2'b00, r[24:22]};
    f3 = r[27:25];
    alt = r[28] && (f3 == 3'd0 || f3 == 3'd5);
    case (r[31:29])
      3'd0, 3'd1, 3'd2: return enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
      3'd3, 3'd4, 3'd5: begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
          return enc_shift(f3, alt, rs1, k[31:26], rd);
        end
        return enc_i(k[31:20], rs1, f3, rd);
      end
      3'd6: return enc_u(k[31:12], rd);
      default: return {k[31:7], 7'b0001011};
    endcase
  endfunction

  task automatic build_program();
    logic [31:0] seed;
    seed = 32'd55184;
    // lui and op-imm with negative immediates
    add_inst(enc_u(20'h80000, 5'd1), "lui");
    add_inst(enc_u(20'h7ffff, 5'd2), "lui");
    add_inst(enc_i(12'hfff, 5'd0, 3'd0, 5'd3), "addi_neg");
    add_inst(enc_i(12'h800, 5'd2, 3'd0, 5'd4), "addi_neg");
    add_inst(enc_i(12'hf00, 5'd1, 3'd2, 5'd5), "slti");
    add_inst(enc_i(12'hfff, 5'd1, 3'd3, 5'd5), "sltiu");
    add_inst(enc_i(12'h8f0, 5'd2, 3'd4, 5'd5), "xori");
    add_inst(enc_i(12'h80f, 5'd1, 3'd6, 5'd5), "ori");
    add_inst(enc_i(12'hf0f, 5'd2, 3'd7, 5'd5), "andi");
    // every shift amount on a negative value
    for (int s = 0; s < 64; s++) begin
      add_inst(enc_shift(3'd1, 1'b0, 5'd1, 6'(s), 5'd5), "slli");
      add_inst(enc_shift(3'd5, 1'b0, 5'd1, 6'(s), 5'd6), "srli");
      add_inst(enc_shift(3'd5, 1'b1, 5'd1, 6'(s), 5'd7), "srai");
    end
    // x6 = int64 min, x7 = int64 max, x3 = -1
    add_inst(enc_i(12'h001, 5'd0, 3'd0, 5'd6), "rtype_setup");
    add_inst(enc_shift(3'd1, 1'b0, 5'd6, 6'd63, 5'd6), "rtype_setup");
    add_inst(enc_i(12'hfff, 5'd6, 3'd0, 5'd7), "rtype_setup");
    for (int f = 0; f < 8; f++) begin
      add_inst(enc_r(7'h00, 5'd7, 5'd6, 3'(f), 5'd5), "rtype");
      add_inst(enc_r(7'h00, 5'd6, 5'd7, 3'(f), 5'd5), "rtype");
      add_inst(enc_r(7'h00, 5'd3, 5'd6, 3'(f), 5'd5), "rtype");
    end
    add_inst(enc_r(7'h20, 5'd7, 5'd6, 3'd0, 5'd5), "sub");
    add_inst(enc_r(7'h20, 5'd6, 5'd0, 3'd0, 5'd5), "sub");
    add_inst(enc_r(7'h20, 5'd3, 5'd6, 3'd5, 5'd5), "sra");
    add_inst(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd5), "sra");
    // each reads the previous rd
    for (int i = 0; i < 8; i++) begin
      add_inst(enc_i(12'h7ff, 5'd1, 3'd0, 5'd1), "chain_addi");
    end
    // seven independent writers to fill the witf
    for (int i = 1; i < 8; i++) begin
      add_inst(enc_i(12'(i * 3), 5'd0, 3'd0, 5'(i)), "chain_fill");
    end
    add_inst(enc_r(7'h00, 5'd7, 5'd1, 3'd0, 5'd2), "chain_use");
    add_inst(enc_r(7'h20, 5'd2, 5'd6, 3'd0, 5'd3), "chain_use");
    // x0 stays zero and an unknown opcode leaves x5 alone
    add_inst(enc_i(12'h123, 5'd3, 3'd0, 5'd0), "x0_write");
    add_inst(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd5), "x0_read");
    add_inst(enc_i(12'd77, 5'd0, 3'd0, 5'd5), "x0_read");
    add_inst({12'h055, 5'd1, 3'd0, 5'd5, 7'b0001011}, "unknown_op");
    add_inst(enc_r(7'h00, 5'd0, 5'd5, 3'd0, 5'd6), "unknown_op");
    for (int i = 0; i < NUM_RANDOM; i++) begin
      add_inst(rand_inst(seed), "random");
    end
  endtask

  initial begin : main
    bit took;
    i_rst = 1'b1;
    i_inst_valid = 1'b0;
    i_inst = '0;
    errors = 0;
    retired = 0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    build_program();
    prog_ready = 1'b1;
    // outputs quiet during reset
    repeat (2) begin
      @(posedge clk);
      @(negedge clk);
      check_value("reset o_valid", '0, XLEN'(o_valid));
      check_value("reset o_wb_en", '0, XLEN'(o_wb_en));
    end
    @(posedge clk);
    i_rst <= 1'b0;
    @(negedge clk);
    check_value("after_reset o_valid", '0, XLEN'(o_valid));
    check_value("after_reset o_wb_en", '0, XLEN'(o_wb_en));
    check_value("after_reset o_inst_ready", 64'd1, XLEN'(o_inst_ready));
    @(posedge clk);
    for (int i = 0; i < prog_q.size(); i++) begin
      i_inst_valid <= 1'b1;
      i_inst <= prog_q[i];
      took = 1'b0;
      // ready sampled mid-cycle and acceptance on the next edge
      while (!took) begin
        @(negedge clk);
        took = o_inst_ready;
        @(posedge clk);
      end
      exp_q.push_back(prog_q[i]);
      exp_name_q.push_back(name_q[i]);
    end
    i_inst_valid <= 1'b0;
    wait (retired == prog_q.size());
    repeat (5) @(posedge clk);
    $display("%0d errors, %0d of %0d instructions retired", errors, retired, prog_q.size());
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // retire checker against the model
  always @(negedge clk) begin : compare_retire
    logic [INST_W-1:0] inst;
    string             name;
    logic              exp_wr;
    logic [4:0]        exp_rd;
    logic [XLEN-1:0]   exp_res;
    if (!i_rst && o_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Error: an instruction retired that was never sent, pc %h", o_pc);
      end else begin
        inst = exp_q.pop_front();
        name = exp_name_q.pop_front();
        ref_exec(inst, model_regs, exp_wr, exp_rd, exp_res);
        check_value({name, " pc"}, RESET_PC + XLEN'(4 * retired), o_pc);
        check_value({name, " inst"}, XLEN'(inst), XLEN'(o_inst));
        check_value({name, " wb_en"}, XLEN'(exp_wr), XLEN'(o_wb_en));
        if (exp_wr) begin
          check_value({name, " rd"}, XLEN'(exp_rd), XLEN'(o_wb_rd));
          check_value({name, " data"}, exp_res, o_wb_data);
          if (exp_rd != 5'd0) begin
            model_regs[exp_rd] = exp_res;
          end
        end
        retired++;
      end
    end
  end

  // stalls cost a few cycles per instruction
  initial begin : watchdog
    int limit;
    wait (prog_ready);
    limit = prog_q.size() * 8 + 100;
    repeat (limit) @(posedge clk);
    $display("Timeout: only %0d of %0d instructions retired within %0d cycles",
             retired, prog_q.size(), limit);
    $display("Test failed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+verification
logic/rv_core_pkg.sv
logic/pipe_links.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/witf.sv
logic/regfile.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/core_top.sv
verification/tb_core_top.sv
